/* source/cache_params.sv */
package cache_params;

    localparam int addr_width  = 32;
    localparam int word_width  = 32;
    localparam int line_width  = 128;
    localparam int offset_bits = 4;
    localparam int index_bits  = 3;
    localparam int tag_bits    = 25;
    localparam int num_sets    = 8;

    // the address splits as tag, then set index, then byte offset in the line.
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [addr_width-1:0]     addr;
        logic [word_width-1:0]     wdata;
        logic [word_width/8-1:0]   byte_enable;
    } cpu_req_t;

    typedef struct packed {
        logic                  resp;
        logic [word_width-1:0] rdata;
    } cpu_rsp_t;

    // memory addresses are always line aligned.
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [line_width-1:0] wdata;
    } pmem_req_t;

    typedef struct packed {
        logic                  resp;
        logic [line_width-1:0] rdata;
    } pmem_rsp_t;

endpackage

/* source/cache_types.sv */
package cache_types;

    // selects which way an array update goes to.
    typedef enum logic {
        w_hit,
        w_lru
    } way_sel_t;

    typedef enum logic {
        d_cpu,
        d_mem
    } data_sel_t;

    typedef enum logic {
        p_cpu,
        p_cache
    } pmem_addr_sel_t;

    typedef enum logic [1:0] {
        idle,
        compare,
        evict,
        load
    } cache_state_t;

    typedef struct packed {
        logic           ld_valid;
        logic           ld_dirty;
        logic           ld_tag;
        logic           ld_data;
        logic           ld_plru;
        logic           dirty_val;
        way_sel_t       dirty_way;
        way_sel_t       data_way;
        data_sel_t      data_sel;
        pmem_addr_sel_t pmem_addr_sel;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic lru_dirty;
    } cache_status_t;

    typedef struct packed {
        logic start;
        logic hit;
        logic miss;
        logic done;
    } perf_evt_t;

    typedef struct packed {
        logic [31:0] access_count;
        logic [31:0] miss_count;
        logic [31:0] busy_cycles;
    } perf_counts_t;

endpackage

/* source/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_read,
    input  logic                       req_write,
    input  logic                       pmem_resp,
    input  cache_types::cache_status_t status,
    output logic                       resp,
    output logic                       pmem_read,
    output logic                       pmem_write,
    output cache_types::cache_ctrl_t   ctrl,
    output cache_types::perf_evt_t     perf_evt,
    output cache_types::cache_state_t  state
);

    cache_types::cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_types::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // every output starts inactive and each state raises only what it needs.
        next_state         = state;
        resp               = 1'b0;
        pmem_read          = 1'b0;
        pmem_write         = 1'b0;
        ctrl.ld_valid      = 1'b0;
        ctrl.ld_dirty      = 1'b0;
        ctrl.ld_tag        = 1'b0;
        ctrl.ld_data       = 1'b0;
        ctrl.ld_plru       = 1'b0;
        ctrl.dirty_val     = 1'b0;
        ctrl.dirty_way     = cache_types::w_hit;
        ctrl.data_way      = cache_types::w_hit;
        ctrl.data_sel      = cache_types::d_cpu;
        ctrl.pmem_addr_sel = cache_types::p_cpu;
        perf_evt           = '0;

        case (state)
            cache_types::idle: begin
                if (req_read || req_write) begin
                    next_state     = cache_types::compare;
                    perf_evt.start = 1'b1;
                end
            end

            cache_types::compare: begin
                if (status.hit) begin
                    if (req_write) begin
                        ctrl.ld_data   = 1'b1;
                        ctrl.data_way  = cache_types::w_hit;
                        ctrl.data_sel  = cache_types::d_cpu;
                        ctrl.ld_dirty  = 1'b1;
                        ctrl.dirty_way = cache_types::w_hit;
                        ctrl.dirty_val = 1'b1;
                    end
                    ctrl.ld_plru  = 1'b1;
                    resp          = 1'b1;
                    perf_evt.hit  = 1'b1;
                    perf_evt.done = 1'b1;
                    next_state    = cache_types::idle;
                end else begin
                    perf_evt.miss = 1'b1;
                    if (status.lru_dirty) begin
                        next_state = cache_types::evict;
                    end else begin
                        next_state = cache_types::load;
                    end
                end
            end

            cache_types::evict: begin
                ctrl.pmem_addr_sel = cache_types::p_cache;
                pmem_write         = 1'b1;
                if (pmem_resp) begin
                    next_state = cache_types::load;
                end
            end

            cache_types::load: begin
                ctrl.pmem_addr_sel = cache_types::p_cpu;
                ctrl.data_way      = cache_types::w_lru;
                ctrl.data_sel      = cache_types::d_mem;
                ctrl.dirty_way     = cache_types::w_lru;
                pmem_read          = 1'b1;
                // the line is only written once memory returns it.
                if (pmem_resp) begin
                    ctrl.ld_data  = 1'b1;
                    ctrl.ld_tag   = 1'b1;
                    ctrl.ld_valid = 1'b1;
                    ctrl.ld_dirty = 1'b1;
                    next_state    = cache_types::compare;
                end
            end

            default: begin
                next_state = cache_types::idle;
            end
        endcase
    end

endmodule

/* source/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
    input  logic                                     clk,
    input  logic                                     rst,
    input  cache_params::cpu_req_t                   cpu_req,
    input  cache_types::cache_ctrl_t                 ctrl,
    input  logic [cache_params::line_width-1:0]      pmem_rdata,
    output cache_types::cache_status_t               status,
    output logic [cache_params::word_width-1:0]      rdata,
    output logic [cache_params::addr_width-1:0]      pmem_addr,
    output logic [cache_params::line_width-1:0]      pmem_wdata
);

    logic [cache_params::tag_bits-1:0]   tag_arr   [2][cache_params::num_sets];
    logic [cache_params::line_width-1:0] data_arr  [2][cache_params::num_sets];
    logic [cache_params::num_sets-1:0]   valid_arr [2];
    logic [cache_params::num_sets-1:0]   dirty_arr [2];
    // each bit names the less recently used way of its set.
    logic [cache_params::num_sets-1:0]   plru;

    logic [cache_params::tag_bits-1:0]      req_tag;
    logic [cache_params::index_bits-1:0]    idx;
    logic [cache_params::offset_bits-3:0]   word_off;
    logic [1:0]                             hit_vec;
    logic                                   hit_way;
    logic                                   lru_way;
    logic                                   data_way;
    logic                                   dirty_way;
    logic [cache_params::line_width-1:0]    merged_line;
    logic [cache_params::line_width-1:0]    new_line;

    assign req_tag  = cpu_req.addr[cache_params::addr_width-1 -: cache_params::tag_bits];
    assign idx      = cpu_req.addr[cache_params::offset_bits +: cache_params::index_bits];
    assign word_off = cpu_req.addr[cache_params::offset_bits-1:2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = valid_arr[w][idx] && (tag_arr[w][idx] == req_tag);
        end
    end

    assign hit_way = hit_vec[1];
    assign lru_way = plru[idx];

    assign status = '{
        hit:       |hit_vec,
        lru_dirty: valid_arr[lru_way][idx] && dirty_arr[lru_way][idx]
    };

    assign data_way  = (ctrl.data_way == cache_types::w_hit) ? hit_way : lru_way;
    assign dirty_way = (ctrl.dirty_way == cache_types::w_hit) ? hit_way : lru_way;

    always_comb begin
        merged_line = data_arr[data_way][idx];
        for (int b = 0; b < cache_params::word_width / 8; b++) begin
            if (cpu_req.byte_enable[b]) begin
                merged_line[word_off * cache_params::word_width + b * 8 +: 8] =
                    cpu_req.wdata[b * 8 +: 8];
            end
        end
        if (ctrl.data_sel == cache_types::d_mem) begin
            new_line = pmem_rdata;
        end else begin
            new_line = merged_line;
        end
    end

    assign rdata = data_arr[hit_way][idx][word_off * cache_params::word_width +:
                                          cache_params::word_width];

    // write-back uses the victim line and the address rebuilt from its stored tag.
    assign pmem_wdata = data_arr[lru_way][idx];

    always_comb begin
        if (ctrl.pmem_addr_sel == cache_types::p_cache) begin
            pmem_addr = {tag_arr[lru_way][idx], idx, {cache_params::offset_bits{1'b0}}};
        end else begin
            pmem_addr = {cpu_req.addr[cache_params::addr_width-1:cache_params::offset_bits],
                         {cache_params::offset_bits{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_data) begin
            data_arr[data_way][idx] <= new_line;
        end
        if (ctrl.ld_tag) begin
            tag_arr[lru_way][idx] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
            end
            plru <= '0;
        end else begin
            if (ctrl.ld_valid) begin
                valid_arr[lru_way][idx] <= 1'b1;
            end
            if (ctrl.ld_dirty) begin
                dirty_arr[dirty_way][idx] <= ctrl.dirty_val;
            end
            if (ctrl.ld_plru) begin
                plru[idx] <= ~hit_way;
            end
        end
    end

endmodule

/* source/cache_perf.sv */
`timescale 1ns/1ps

module cache_perf (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_types::perf_evt_t    perf_evt,
    input  cache_types::cache_state_t state,
    output cache_types::perf_counts_t counts
);

    // counters stop at their maximum instead of wrapping.
    function automatic logic [31:0] sat_inc(input logic [31:0] value);
        if (&value) begin
            return value;
        end
        return value + 32'd1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            if (perf_evt.start) begin
                counts.access_count <= sat_inc(counts.access_count);
            end
            if (perf_evt.miss) begin
                counts.miss_count <= sat_inc(counts.miss_count);
            end
            // any cycle outside idle is spent serving a request.
            if (state != cache_types::idle) begin
                counts.busy_cycles <= sat_inc(counts.busy_cycles);
            end
        end
    end

endmodule

/* source/cache.sv */
`timescale 1ns/1ps

module cache (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_params::cpu_req_t    cpu_req,
    output cache_params::cpu_rsp_t    cpu_rsp,
    output cache_params::pmem_req_t   pmem_req,
    input  cache_params::pmem_rsp_t   pmem_rsp,
    output cache_types::perf_counts_t counts
);

    cache_types::cache_ctrl_t            ctrl;
    cache_types::cache_status_t          status;
    cache_types::perf_evt_t              perf_evt;
    cache_types::cache_state_t           state;
    logic                                resp;
    logic                                pmem_read;
    logic                                pmem_write;
    logic [cache_params::word_width-1:0] rdata;
    logic [cache_params::addr_width-1:0] pmem_addr;
    logic [cache_params::line_width-1:0] pmem_wdata;

    cache_control control_i (
        .clk        (clk),
        .rst        (rst),
        .req_read   (cpu_req.read),
        .req_write  (cpu_req.write),
        .pmem_resp  (pmem_rsp.resp),
        .status     (status),
        .resp       (resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl),
        .perf_evt   (perf_evt),
        .state      (state)
    );

    cache_datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .ctrl       (ctrl),
        .pmem_rdata (pmem_rsp.rdata),
        .status     (status),
        .rdata      (rdata),
        .pmem_addr  (pmem_addr),
        .pmem_wdata (pmem_wdata)
    );

    cache_perf perf_i (
        .clk      (clk),
        .rst      (rst),
        .perf_evt (perf_evt),
        .state    (state),
        .counts   (counts)
    );

    assign cpu_rsp  = '{resp: resp, rdata: rdata};
    assign pmem_req = '{read: pmem_read, write: pmem_write, addr: pmem_addr, wdata: pmem_wdata};

endmodule

/* testbench/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_params::cpu_req_t    cpu_req,
    input  cache_params::cpu_rsp_t    cpu_rsp,
    input  cache_params::pmem_req_t   pmem_req,
    input  cache_params::pmem_rsp_t   pmem_rsp,
    input  cache_types::perf_counts_t counts,
    input  logic                      final_check,
    output int                        errors
);

    // flat copy of the 32 lines that the stimulus can reach, one word per entry.
    logic [31:0]                       ref_mem [128];
    logic [cache_params::tag_bits-1:0] tags [2][8];
    logic                              valid [2][8];
    logic                              dirty [2][8];
    logic                              lru [8];
    logic                              busy;
    logic                              want_hit;
    logic                              want_wb;
    logic                              saw_rd;
    logic                              saw_wr;
    logic                              way;
    logic [2:0]                        set;
    logic [31:0]                       line_addr;
    int                                held;
    int                                requests;
    int                                misses;
    int                                req_cycles;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic [127:0] ref_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w * 32 +: 32] = ref_mem[{addr[8:4], 2'(w)}];
        end
        return line;
    endfunction

    task automatic count_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 128; i++) begin
                ref_mem[i] = fill_word(i * 4);
            end
            for (int s = 0; s < 8; s++) begin
                valid[0][s] = 1'b0;
                valid[1][s] = 1'b0;
                dirty[0][s] = 1'b0;
                dirty[1][s] = 1'b0;
                lru[s] = 1'b0;
            end
            busy = 1'b0;
            errors = 0;
            held = 0;
            requests = 0;
            misses = 0;
        end else begin
            if (!busy) begin
                if (cpu_rsp.resp || pmem_req.read || pmem_req.write) begin
                    count_error("cache drives resp or memory traffic while idle");
                end
                if (requests == 0 && counts !== '0) begin
                    count_error($sformatf("mismatch counts: got %h expected 0", counts));
                end
                if (cpu_req.read || cpu_req.write) begin
                    busy = 1'b1;
                    requests++;
                    req_cycles = 0;
                    saw_rd = 1'b0;
                    saw_wr = 1'b0;
                    want_hit = 1'b0;
                    want_wb = 1'b0;
                    set = cpu_req.addr[6:4];
                    for (int w = 0; w < 2; w++) begin
                        if (valid[w][set] && tags[w][set] == cpu_req.addr[31:7]) begin
                            want_hit = 1'b1;
                            way = w[0];
                        end
                    end
                    if (!want_hit) begin
                        misses++;
                        way = lru[set];
                        want_wb = valid[way][set] && dirty[way][set];
                    end
                end
            end
            if (busy) begin
                held++;
                req_cycles++;
                if (want_hit && (pmem_req.read || pmem_req.write)) begin
                    count_error("memory traffic on a request that should hit");
                end
                if (pmem_req.write && pmem_rsp.resp) begin
                    saw_wr = 1'b1;
                    line_addr = {tags[way][set], set, 4'b0000};
                    if (!want_wb) begin
                        count_error("write-back of a line that is not dirty");
                    end else begin
                        if (pmem_req.addr !== line_addr) begin
                            count_error($sformatf("mismatch pmem_req.addr: got %h expected %h",
                                                  pmem_req.addr, line_addr));
                        end
                        if (pmem_req.wdata !== ref_line(line_addr)) begin
                            count_error($sformatf("mismatch pmem_req.wdata: got %h expected %h",
                                                  pmem_req.wdata, ref_line(line_addr)));
                        end
                    end
                end
                if (pmem_req.read && pmem_rsp.resp) begin
                    saw_rd = 1'b1;
                    if (want_wb && !saw_wr) begin
                        count_error("refill started before the dirty line was written back");
                    end
                    if (pmem_req.addr !== {cpu_req.addr[31:4], 4'b0000}) begin
                        count_error($sformatf("mismatch pmem_req.addr: got %h expected %h",
                                              pmem_req.addr, {cpu_req.addr[31:4], 4'b0000}));
                    end
                end
                if (cpu_rsp.resp) begin
                    if (want_hit && req_cycles != 2) begin
                        count_error($sformatf("hit answered in cycle %0d of the request",
                                              req_cycles));
                    end
                    if (!want_hit && !saw_rd) begin
                        count_error("miss answered without a refill");
                    end
                    if (want_wb && !saw_wr) begin
                        count_error("dirty victim replaced without a write-back");
                    end
                    if (cpu_req.read && cpu_rsp.rdata !== ref_mem[cpu_req.addr[8:2]]) begin
                        count_error($sformatf("mismatch cpu_rsp.rdata: got %h expected %h",
                                              cpu_rsp.rdata, ref_mem[cpu_req.addr[8:2]]));
                    end
                    if (cpu_req.write) begin
                        for (int b = 0; b < 4; b++) begin
                            if (cpu_req.byte_enable[b]) begin
                                ref_mem[cpu_req.addr[8:2]][b * 8 +: 8] = cpu_req.wdata[b * 8 +: 8];
                            end
                        end
                    end
                    // a refill lands in the victim way clean, then the access itself hits.
                    if (!want_hit) begin
                        tags[way][set] = cpu_req.addr[31:7];
                        valid[way][set] = 1'b1;
                        dirty[way][set] = 1'b0;
                    end
                    if (cpu_req.write) begin
                        dirty[way][set] = 1'b1;
                    end
                    lru[set] = ~way;
                    busy = 1'b0;
                end
            end
            if (final_check) begin
                if (counts.access_count !== requests) begin
                    count_error($sformatf("mismatch access_count: got %h expected %h",
                                          counts.access_count, requests));
                end
                if (counts.miss_count !== misses) begin
                    count_error($sformatf("mismatch miss_count: got %h expected %h",
                                          counts.miss_count, misses));
                end
                if (counts.busy_cycles !== held - requests) begin
                    count_error($sformatf("mismatch busy_cycles: got %h expected %h",
                                          counts.busy_cycles, held - requests));
                end
            end
        end
    end

endmodule

/* testbench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int num_requests   = 300;
    localparam int timeout_cycles = num_requests * 40;

    logic                      clk;
    logic                      rst;
    logic                      final_check;
    cache_params::cpu_req_t    cpu_req;
    cache_params::cpu_rsp_t    cpu_rsp;
    cache_params::pmem_req_t   pmem_req;
    cache_params::pmem_rsp_t   pmem_rsp = '0;
    cache_types::perf_counts_t counts;
    int                        errors;
    int                        cycles = 0;
    logic [15:0]               stim_lfsr;
    logic [15:0]               delay_lfsr;
    logic [127:0]              pmem [32];
    logic                      pmem_busy;
    logic [1:0]                pmem_delay;

    cache dut_i (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .pmem_req (pmem_req),
        .pmem_rsp (pmem_rsp),
        .counts   (counts)
    );

    cache_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_rsp     (cpu_rsp),
        .pmem_req    (pmem_req),
        .pmem_rsp    (pmem_rsp),
        .counts      (counts),
        .final_check (final_check),
        .errors      (errors)
    );

    always #2 clk = ~clk;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1, the output bit is bit 0.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_next(stim_lfsr);
        end
    endtask

    // memory model that answers each transfer after one to four cycles.
    always @(negedge clk) begin
        pmem_rsp.resp = 1'b0;
        if (rst) begin
            pmem_busy = 1'b0;
            delay_lfsr = 16'd31247;
            for (int i = 0; i < 32; i++) begin
                for (int w = 0; w < 4; w++) begin
                    pmem[i][w * 32 +: 32] = fill_word(i * 16 + w * 4);
                end
            end
        end else if (pmem_req.read || pmem_req.write) begin
            if (!pmem_busy) begin
                pmem_busy = 1'b1;
                pmem_delay[1] = delay_lfsr[0];
                delay_lfsr = lfsr_next(delay_lfsr);
                pmem_delay[0] = delay_lfsr[0];
                delay_lfsr = lfsr_next(delay_lfsr);
            end
            if (pmem_delay == 2'd0) begin
                pmem_rsp.resp = 1'b1;
                pmem_busy = 1'b0;
                if (pmem_req.write) begin
                    pmem[pmem_req.addr[8:4]] = pmem_req.wdata;
                end else begin
                    pmem_rsp.rdata = pmem[pmem_req.addr[8:4]];
                end
            end else begin
                pmem_delay = pmem_delay - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == timeout_cycles) begin
            $display("timeout: run did not end within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] word_sel;
        logic [31:0] bits;
        clk = 1'b0;
        rst = 1'b1;
        final_check = 1'b0;
        cpu_req = '0;
        stim_lfsr = 16'd31247;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        for (int n = 0; n < num_requests; n++) begin
            draw_bits(2, bits);
            if (bits[1:0] == 2'd0) begin
                @(negedge clk);
            end
            // four tags per set, words 0 and 2 of each line.
            draw_bits(6, word_sel);
            cpu_req.addr = {23'd0, word_sel[5:4], word_sel[3:1], word_sel[0], 3'b000};
            draw_bits(1, bits);
            cpu_req.read = !bits[0];
            cpu_req.write = bits[0];
            draw_bits(32, bits);
            cpu_req.wdata = bits;
            draw_bits(4, bits);
            cpu_req.byte_enable = bits[3:0];
            @(posedge clk);
            while (!cpu_rsp.resp) begin
                @(posedge clk);
            end
            @(negedge clk);
            cpu_req = '0;
        end
        final_check = 1'b1;
        @(negedge clk);
        final_check = 1'b0;
        $display("requests: %0d, errors: %0d", num_requests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* cache.f */
source/cache_params.sv
source/cache_types.sv
source/cache_control.sv
source/cache_datapath.sv
source/cache_perf.sv
source/cache.sv
testbench/cache_checker.sv
testbench/cache_tb.sv
